/* logic/alu.sv */
`timescale 1ns/1ps

module alu (
    input  logic [rvPkg::xlen-1:0] a,
    input  logic [rvPkg::xlen-1:0] b,
    input  logic [3:0]             aluOp,
    output logic [rvPkg::xlen-1:0] result,
    output logic                   zero
);
    import rvPkg::*;

    logic lessThan;

    assign lessThan = ($signed(a) < $signed(b));

    always_comb begin
        case (aluOp)
            aluAdd: begin
                result = a + b;
            end
            aluSub: begin
                result = a - b;
            end
            aluAnd: begin
                result = a & b;
            end
            aluOr: begin
                result = a | b;
            end
            aluXor: begin
                result = a ^ b;
            end
            aluSlt: begin
                result = {{(xlen-1){1'b0}}, lessThan};
            end
            // upper immediate goes straight through
            aluPassB: begin
                result = b;
            end
            default: begin
                result = '0;
            end
        endcase
    end

    assign zero = (result == '0);

endmodule

/* logic/cpu.sv */
`timescale 1ns/1ps

module cpu (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [rvPkg::xlen-1:0] instruction,
    input  logic [rvPkg::xlen-1:0] memReadData,
    input  logic                   irq,
    output logic [rvPkg::xlen-1:0] pc,
    output logic                   memWr,
    output logic [3:0]             wrMask,
    output logic [rvPkg::xlen-1:0] memAddr,
    output logic [rvPkg::xlen-1:0] memWriteData
);
    import rvPkg::*;

    logic [3:0]      aluOp;
    logic            srcASel;
    logic            srcBImm;
    logic            regWr;
    logic [1:0]      wbSel;
    logic            storeEn;
    logic            memSize;
    logic            loadUnsigned;
    logic            branchTaken;
    logic            jump;
    logic            csrWr;
    logic            ecall;
    logic            mret;
    logic            aluZero;
    logic            trapTaken;
    logic [xlen-1:0] imm;
    logic [xlen-1:0] rs1Data;
    logic [xlen-1:0] rs2Data;
    logic [xlen-1:0] srcA;
    logic [xlen-1:0] srcB;
    logic [xlen-1:0] aluResult;
    logic [xlen-1:0] loadData;
    logic [xlen-1:0] csrData;
    logic [xlen-1:0] trapVector;
    logic [xlen-1:0] mepcOut;
    logic [xlen-1:0] pc4;
    logic [xlen-1:0] branchTarget;
    logic [xlen-1:0] pcNext;
    logic [xlen-1:0] wbData;

    instrDecoder i_decoder (
        .instruction  (instruction),
        .aluZero      (aluZero),
        .aluOp        (aluOp),
        .srcASel      (srcASel),
        .srcBImm      (srcBImm),
        .regWr        (regWr),
        .wbSel        (wbSel),
        .memWr        (storeEn),
        .memSize      (memSize),
        .loadUnsigned (loadUnsigned),
        .branchTaken  (branchTaken),
        .jump         (jump),
        .csrWr        (csrWr),
        .ecall        (ecall),
        .mret         (mret),
        .imm          (imm)
    );

    regFile i_regFile (
        .clk     (clk),
        .rs1Addr (instruction[19:15]),
        .rs2Addr (instruction[24:20]),
        .rdAddr  (instruction[11:7]),
        .rdData  (wbData),
        .rdWr    (regWr),
        .rs1Data (rs1Data),
        .rs2Data (rs2Data)
    );

    assign srcA = srcASel ? pc : rs1Data;
    assign srcB = srcBImm ? imm : rs2Data;

    alu i_alu (
        .a      (srcA),
        .b      (srcB),
        .aluOp  (aluOp),
        .result (aluResult),
        .zero   (aluZero)
    );

    csrUnit i_csr (
        .clk        (clk),
        .reset      (reset),
        .csrAddr    (instruction[31:20]),
        .csrWr      (csrWr),
        .csrWData   (aluResult),
        .ecall      (ecall),
        .mret       (mret),
        .irq        (irq),
        .pcCur      (pc),
        .pcNext     (pcNext),
        .csrData    (csrData),
        .trapTaken  (trapTaken),
        .trapVector (trapVector),
        .mepcOut    (mepcOut)
    );

    assign memAddr = aluResult;

    // no store leaves the core while in reset
    assign memWr = storeEn && !reset;

    loadStoreAlign i_lsAlign (
        .addrLow      (aluResult[1:0]),
        .memSize      (memSize),
        .loadUnsigned (loadUnsigned),
        .storeData    (rs2Data),
        .memReadData  (memReadData),
        .memWriteData (memWriteData),
        .wrMask       (wrMask),
        .loadData     (loadData)
    );

    always_comb begin
        case (wbSel)
            wbAlu:   wbData = aluResult;
            wbMem:   wbData = loadData;
            wbPc4:   wbData = pc4;
            default: wbData = csrData;
        endcase
    end

    assign pc4          = pc + 32'd4;
    assign branchTarget = pc + imm;

    // jal target comes out of the alu
    assign pcNext = mret        ? mepcOut :
                    jump        ? aluResult :
                    branchTaken ? branchTarget : pc4;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;
        end else begin
            pc <= trapTaken ? trapVector : pcNext;
        end
    end

endmodule

/* logic/csrUnit.sv */
`timescale 1ns/1ps

module csrUnit (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [11:0]            csrAddr,
    input  logic                   csrWr,
    input  logic [rvPkg::xlen-1:0] csrWData,
    input  logic                   ecall,
    input  logic                   mret,
    input  logic                   irq,
    input  logic [rvPkg::xlen-1:0] pcCur,
    input  logic [rvPkg::xlen-1:0] pcNext,
    output logic [rvPkg::xlen-1:0] csrData,
    output logic                   trapTaken,
    output logic [rvPkg::xlen-1:0] trapVector,
    output logic [rvPkg::xlen-1:0] mepcOut
);
    import rvPkg::*;

    logic            mie;
    logic [xlen-1:0] mtvec;
    logic [xlen-1:0] mepc;
    logic [xlen-1:0] mcause;
    logic            irqTaken;
    logic [xlen-1:0] trapCause;
    logic [xlen-1:0] vectorBase;

    // ecall wins over a pending interrupt
    assign irqTaken  = irq && mie && !ecall;
    assign trapTaken = ecall || (irq && mie);
    assign trapCause = ecall ? {1'b0, causeEcall} : {1'b1, causeExtIrq};

    assign vectorBase = {mtvec[xlen-1:2], 2'b00};
    assign trapVector = (mtvec[0] && irqTaken) ?
                        vectorBase + {trapCause[xlen-3:0], 2'b00} : vectorBase;

    always_comb begin
        case (csrAddr)
            csrMstatus: csrData = {{(xlen-4){1'b0}}, mie, 3'b000};
            csrMtvec:   csrData = mtvec;
            csrMepc:    csrData = mepc;
            csrMcause:  csrData = mcause;
            default:    csrData = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            mie    <= 1'b0;
            mtvec  <= '0;
            mepc   <= '0;
            mcause <= '0;
        end else begin
            if (csrWr && csrAddr == csrMtvec) begin
                mtvec <= csrWData;
            end
            if (trapTaken) begin
                mie    <= 1'b0;
                mepc   <= ecall ? pcCur : pcNext;
                mcause <= trapCause;
            end else begin
                if (mret) begin
                    mie <= 1'b1;
                end else if (csrWr && csrAddr == csrMstatus) begin
                    mie <= csrWData[3];
                end
                if (csrWr && csrAddr == csrMepc) begin
                    mepc <= csrWData;
                end
                if (csrWr && csrAddr == csrMcause) begin
                    mcause <= csrWData;
                end
            end
        end
    end

    assign mepcOut = mepc;

endmodule

/* logic/instrDecoder.sv */
`timescale 1ns/1ps

module instrDecoder (
    input  logic [rvPkg::xlen-1:0] instruction,
    input  logic                   aluZero,
    output logic [3:0]             aluOp,
    output logic                   srcASel,
    output logic                   srcBImm,
    output logic                   regWr,
    output logic [1:0]             wbSel,
    output logic                   memWr,
    output logic                   memSize,
    output logic                   loadUnsigned,
    output logic                   branchTaken,
    output logic                   jump,
    output logic                   csrWr,
    output logic                   ecall,
    output logic                   mret,
    output logic [rvPkg::xlen-1:0] imm
);
    import rvPkg::*;

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [11:0]     funct12;
    logic [xlen-1:0] immI;
    logic [xlen-1:0] immS;
    logic [xlen-1:0] immB;
    logic [xlen-1:0] immU;
    logic [xlen-1:0] immJ;

    assign opcode  = instruction[6:0];
    assign funct3  = instruction[14:12];
    assign funct12 = instruction[31:20];

    assign immI = {{20{instruction[31]}}, instruction[31:20]};
    assign immS = {{20{instruction[31]}}, instruction[31:25], instruction[11:7]};
    assign immB = {{19{instruction[31]}}, instruction[31], instruction[7],
                   instruction[30:25], instruction[11:8], 1'b0};
    assign immU = {instruction[31:12], 12'b0};
    assign immJ = {{11{instruction[31]}}, instruction[31], instruction[19:12],
                   instruction[20], instruction[30:21], 1'b0};

    always_comb begin
        aluOp        = aluAdd;
        srcASel      = 1'b0;
        srcBImm      = 1'b1;
        regWr        = 1'b0;
        wbSel        = wbAlu;
        memWr        = 1'b0;
        memSize      = 1'b0;
        loadUnsigned = 1'b0;
        branchTaken  = 1'b0;
        jump         = 1'b0;
        csrWr        = 1'b0;
        ecall        = 1'b0;
        mret         = 1'b0;
        imm          = '0;

        case (opcode)
            opOp: begin
                srcBImm = 1'b0;
                regWr   = 1'b1;
                case (funct3)
                    f3Add:   aluOp = instruction[30] ? aluSub : aluAdd;
                    f3Xor:   aluOp = aluXor;
                    f3Or:    aluOp = aluOr;
                    f3And:   aluOp = aluAnd;
                    f3Slt:   aluOp = aluSlt;
                    default: regWr = 1'b0;
                endcase
            end
            opOpImm: begin
                // only ADDI of the immediate group
                imm   = immI;
                regWr = (funct3 == f3Add);
            end
            opLui: begin
                aluOp = aluPassB;
                imm   = immU;
                regWr = 1'b1;
            end
            opLoad: begin
                imm          = immI;
                wbSel        = wbMem;
                regWr        = funct3 inside {f3Lb, f3Lbu, f3Lw};
                memSize      = (funct3 == f3Lw);
                loadUnsigned = (funct3 == f3Lbu);
            end
            opStore: begin
                imm     = immS;
                memWr   = funct3 inside {f3Sb, f3Sw};
                memSize = (funct3 == f3Sw);
            end
            opBranch: begin
                // compare via subtract, target built in cpu
                aluOp   = aluSub;
                srcBImm = 1'b0;
                imm     = immB;
                if (funct3 == f3Beq) begin
                    branchTaken = aluZero;
                end else if (funct3 == f3Bne) begin
                    branchTaken = !aluZero;
                end
            end
            opJal: begin
                // alu forms pc + imm as the target
                srcASel = 1'b1;
                imm     = immJ;
                jump    = 1'b1;
                regWr   = 1'b1;
                wbSel   = wbPc4;
            end
            opSystem: begin
                if (funct3 == f3Csrrw) begin
                    // rs1 + 0 becomes the csr write value
                    csrWr = 1'b1;
                    regWr = 1'b1;
                    wbSel = wbCsr;
                end else if (funct3 == f3Priv) begin
                    ecall = (funct12 == 12'h000);
                    mret  = (funct12 == 12'h302);
                end
            end
            default: begin
                // unknown opcode leaves all controls idle
                regWr = 1'b0;
            end
        endcase
    end

endmodule

/* logic/loadStoreAlign.sv */
`timescale 1ns/1ps

module loadStoreAlign (
    input  logic [1:0]             addrLow,
    input  logic                   memSize,
    input  logic                   loadUnsigned,
    input  logic [rvPkg::xlen-1:0] storeData,
    input  logic [rvPkg::xlen-1:0] memReadData,
    output logic [rvPkg::xlen-1:0] memWriteData,
    output logic [3:0]             wrMask,
    output logic [rvPkg::xlen-1:0] loadData
);
    import rvPkg::*;

    logic [7:0] loadByte;
    logic       signBit;

    // memSize set means a full word
    always_comb begin
        if (memSize) begin
            memWriteData = storeData;
            wrMask       = 4'b1111;
        end else begin
            // byte copied to every lane, mask picks one
            memWriteData = {4{storeData[7:0]}};
            wrMask       = 4'b0001 << addrLow;
        end
    end

    always_comb begin
        case (addrLow)
            2'd0:    loadByte = memReadData[7:0];
            2'd1:    loadByte = memReadData[15:8];
            2'd2:    loadByte = memReadData[23:16];
            default: loadByte = memReadData[31:24];
        endcase
    end

    assign signBit = loadByte[7] && !loadUnsigned;

    always_comb begin
        if (memSize) begin
            loadData = memReadData;
        end else begin
            loadData = {{(xlen-8){signBit}}, loadByte};
        end
    end

endmodule

/* logic/regFile.sv */
`timescale 1ns/1ps

module regFile (
    input  logic                   clk,
    input  logic [4:0]             rs1Addr,
    input  logic [4:0]             rs2Addr,
    input  logic [4:0]             rdAddr,
    input  logic [rvPkg::xlen-1:0] rdData,
    input  logic                   rdWr,
    output logic [rvPkg::xlen-1:0] rs1Data,
    output logic [rvPkg::xlen-1:0] rs2Data
);
    import rvPkg::*;

    logic [xlen-1:0] regs [32];

    always_ff @(posedge clk) begin
        // x0 is never stored
        if (rdWr && rdAddr != 5'd0) begin
            regs[rdAddr] <= rdData;
        end
    end

    assign rs1Data = (rs1Addr == 5'd0) ? '0 : regs[rs1Addr];
    assign rs2Data = (rs2Addr == 5'd0) ? '0 : regs[rs2Addr];

endmodule

/* logic/rvPkg.sv */
package rvPkg;

    localparam int xlen = 32;

    // major opcodes
    localparam logic [6:0] opOp     = 7'b0110011;
    localparam logic [6:0] opOpImm  = 7'b0010011;
    localparam logic [6:0] opLui    = 7'b0110111;
    localparam logic [6:0] opLoad   = 7'b0000011;
    localparam logic [6:0] opStore  = 7'b0100011;
    localparam logic [6:0] opBranch = 7'b1100011;
    localparam logic [6:0] opJal    = 7'b1101111;
    localparam logic [6:0] opSystem = 7'b1110011;

    localparam logic [2:0] f3Add   = 3'b000;
    localparam logic [2:0] f3Xor   = 3'b100;
    localparam logic [2:0] f3Or    = 3'b110;
    localparam logic [2:0] f3And   = 3'b111;
    localparam logic [2:0] f3Slt   = 3'b010;
    localparam logic [2:0] f3Lb    = 3'b000;
    localparam logic [2:0] f3Lbu   = 3'b100;
    localparam logic [2:0] f3Lw    = 3'b010;
    localparam logic [2:0] f3Sb    = 3'b000;
    localparam logic [2:0] f3Sw    = 3'b010;
    localparam logic [2:0] f3Beq   = 3'b000;
    localparam logic [2:0] f3Bne   = 3'b001;
    localparam logic [2:0] f3Csrrw = 3'b001;
    localparam logic [2:0] f3Priv  = 3'b000;

    localparam logic [3:0] aluAdd   = 4'd0;
    localparam logic [3:0] aluSub   = 4'd1;
    localparam logic [3:0] aluAnd   = 4'd2;
    localparam logic [3:0] aluOr    = 4'd3;
    localparam logic [3:0] aluXor   = 4'd4;
    localparam logic [3:0] aluSlt   = 4'd5;
    localparam logic [3:0] aluPassB = 4'd6;

    localparam logic [11:0] csrMstatus = 12'h300;
    localparam logic [11:0] csrMtvec   = 12'h305;
    localparam logic [11:0] csrMepc    = 12'h341;
    localparam logic [11:0] csrMcause  = 12'h342;

    // bit 31 of mcause marks an interrupt
    localparam logic [30:0] causeEcall  = 31'd11;
    localparam logic [30:0] causeExtIrq = 31'd11;

    localparam logic [1:0] wbAlu = 2'd0;
    localparam logic [1:0] wbMem = 2'd1;
    localparam logic [1:0] wbPc4 = 2'd2;
    localparam logic [1:0] wbCsr = 2'd3;

endpackage

/* run.sh */
#!/bin/sh
# build and run the cpu testbench with Verilator

verilator --binary --timing --assert -f sources.f --top-module cpuTb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

output=$(./obj_dir/VcpuTb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "All tests passed"; then
    exit 0
fi
exit 1

/* sources.f */
logic/rvPkg.sv
logic/instrDecoder.sv
logic/alu.sv
logic/regFile.sv
logic/csrUnit.sv
logic/loadStoreAlign.sv
logic/cpu.sv
verification/cpu_props.sv
verification/cpuChecker.sv
verification/cpuTb.sv

/* verification/cpuChecker.sv */
`timescale 1ns/1ps

module cpuChecker (
    input  logic        clk,
    input  logic        reset,
    input  logic [31:0] instruction,
    input  logic [31:0] memReadData,
    input  logic        irq,
    input  logic [31:0] pc,
    input  logic        memWr,
    input  logic [3:0]  wrMask,
    input  logic [31:0] memAddr,
    input  logic [31:0] memWriteData,
    output int          errorCount,
    output logic        ready
);
    import rvPkg::*;

    logic [31:0] regs [32];
    logic [31:0] mPc;
    logic [31:0] mtvec;
    logic [31:0] mepc;
    logic [31:0] mcause;
    logic        mie;

    initial begin
        errorCount = 0;
        ready = 1'b0;
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
    end

    function automatic logic [31:0] csrRead(input logic [11:0] addr);
        case (addr)
            csrMstatus: return {28'd0, mie, 3'b000};
            csrMtvec:   return mtvec;
            csrMepc:    return mepc;
            csrMcause:  return mcause;
            default:    return '0;
        endcase
    endfunction

    task automatic report(input string what, input logic [31:0] exp, input logic [31:0] got);
        $display("[ERROR] %0t %s expected %h got %h", $time, what, exp, got);
        errorCount++;
    endtask

    task automatic step();
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] immI;
        logic [31:0] immS;
        logic [31:0] addr;
        logic [31:0] lane;
        logic [31:0] wval;
        logic [31:0] nextPc;
        logic [31:0] base;
        logic [3:0]  expMask;
        logic [31:0] expData;
        logic        wen;
        logic        expWr;
        logic        isCsr;
        logic        isEcall;
        logic        isMret;
        ins = instruction;
        if (pc !== mPc) begin
            report("pc", mPc, pc);
            mPc = pc;
        end
        a = regs[ins[19:15]];
        b = regs[ins[24:20]];
        immI = {{20{ins[31]}}, ins[31:20]};
        immS = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        addr = a + ((ins[6:0] == opStore) ? immS : immI);
        lane = memReadData >> {addr[1:0], 3'b000};
        nextPc = mPc + 32'd4;
        wen = 1'b0;
        wval = '0;
        expWr = 1'b0;
        expMask = 4'b1111;
        expData = b;
        isCsr = 1'b0;
        isEcall = 1'b0;
        isMret = 1'b0;
        case (ins[6:0])
            opOp: begin
                wen = 1'b1;
                case (ins[14:12])
                    f3Add: wval = ins[30] ? a - b : a + b;
                    f3Xor: wval = a ^ b;
                    f3Or:  wval = a | b;
                    f3And: wval = a & b;
                    f3Slt: wval = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    default: wen = 1'b0;
                endcase
            end
            opOpImm: begin
                wen = (ins[14:12] == f3Add);
                wval = a + immI;
            end
            opLui: begin
                wen = 1'b1;
                wval = {ins[31:12], 12'd0};
            end
            opLoad: begin
                wen = ins[14:12] inside {f3Lb, f3Lbu, f3Lw};
                if (ins[14:12] == f3Lw) begin
                    wval = memReadData;
                end else if (ins[14:12] == f3Lbu) begin
                    wval = {24'd0, lane[7:0]};
                end else begin
                    wval = {{24{lane[7]}}, lane[7:0]};
                end
            end
            opStore: begin
                expWr = ins[14:12] inside {f3Sb, f3Sw};
                if (ins[14:12] == f3Sb) begin
                    expMask = 4'b0001 << addr[1:0];
                    expData = {4{b[7:0]}};
                end
            end
            opBranch: begin
                if ((ins[14:12] == f3Beq && a == b) || (ins[14:12] == f3Bne && a != b)) begin
                    nextPc = mPc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
                end
            end
            opJal: begin
                wen = 1'b1;
                wval = mPc + 32'd4;
                nextPc = mPc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
            end
            opSystem: begin
                if (ins[14:12] == f3Csrrw) begin
                    isCsr = 1'b1;
                    wen = 1'b1;
                    wval = csrRead(ins[31:20]);
                end else if (ins[14:12] == f3Priv) begin
                    isEcall = (ins[31:20] == 12'h000);
                    isMret = (ins[31:20] == 12'h302);
                end
            end
            default: ;
        endcase
        if (memWr !== expWr) begin
            report("memWr", {31'd0, expWr}, {31'd0, memWr});
        end else if (expWr) begin
            if (memAddr !== addr) report("memAddr", addr, memAddr);
            if (wrMask !== expMask) report("wrMask", {28'd0, expMask}, {28'd0, wrMask});
            if (memWriteData !== expData) report("memWriteData", expData, memWriteData);
        end
        if (wen && ins[11:7] != 5'd0) begin
            regs[ins[11:7]] = wval;
        end
        if (isMret) begin
            nextPc = mepc;
        end
        base = {mtvec[31:2], 2'b00};
        if (isEcall) begin
            mepc = mPc;
            mcause = 32'd11;
            mie = 1'b0;
            nextPc = base;
        end else if (irq && mie) begin
            // interrupt code 11 lands 44 bytes above the base
            mepc = nextPc;
            mcause = 32'h8000000B;
            mie = 1'b0;
            nextPc = mtvec[0] ? base + 32'd44 : base;
        end else begin
            if (isMret) mie = 1'b1;
            if (isCsr && ins[31:20] == csrMstatus) mie = a[3];
            if (isCsr && ins[31:20] == csrMepc) mepc = a;
            if (isCsr && ins[31:20] == csrMcause) mcause = a;
        end
        if (isCsr && ins[31:20] == csrMtvec) begin
            mtvec = a;
        end
        mPc = nextPc;
    endtask

    always @(posedge clk) begin
        if (reset) begin
            mPc = '0;
            mtvec = '0;
            mepc = '0;
            mcause = '0;
            mie = 1'b0;
            ready = 1'b0;
        end else begin
            step();
            ready = 1'b1;
        end
    end

endmodule

/* verification/cpuTb.sv */
`timescale 1ns/1ps

module cpuTb;
    import rvPkg::*;

    localparam int progWords    = 64;
    localparam int resetCycles  = 16;
    localparam int runCycles    = 400;
    localparam int readyTimeout = 20;
    localparam int numTests     = 5;
    localparam logic [31:0] lfsrPoly = 32'h80200003;

    logic        clk = 1'b0;
    logic        reset = 1'b1;
    logic        irq = 1'b0;
    logic [31:0] instruction;
    logic [31:0] memReadData;
    logic [31:0] pc;
    logic        memWr;
    logic [3:0]  wrMask;
    logic [31:0] memAddr;
    logic [31:0] memWriteData;
    logic [31:0] imem [progWords];
    logic [31:0] dmem [progWords];
    logic [31:0] lfsrState = 32'd26;
    logic        irqEnable = 1'b0;
    int          errors;
    logic        ready;
    int          failedTests = 0;
    bit          timedOut = 1'b0;
    string       testNames [numTests] = '{"alu and lui", "loads and stores",
                                          "branches and jal", "csr and traps", "vectored irq"};

    always #10 clk = ~clk;

    cpu i_dut (
        .clk          (clk),
        .reset        (reset),
        .instruction  (instruction),
        .memReadData  (memReadData),
        .irq          (irq),
        .pc           (pc),
        .memWr        (memWr),
        .wrMask       (wrMask),
        .memAddr      (memAddr),
        .memWriteData (memWriteData)
    );

    cpuChecker i_checker (
        .clk          (clk),
        .reset        (reset),
        .instruction  (instruction),
        .memReadData  (memReadData),
        .irq          (irq),
        .pc           (pc),
        .memWr        (memWr),
        .wrMask       (wrMask),
        .memAddr      (memAddr),
        .memWriteData (memWriteData),
        .errorCount   (errors),
        .ready        (ready)
    );

    bind cpu cpu_props i_props (
        .clk        (clk),
        .reset      (reset),
        .memWr      (memWr),
        .ecall      (ecall),
        .rs1Addr    (instruction[19:15]),
        .imm        (imm),
        .memAddr    (memAddr),
        .pc         (pc),
        .trapVector (trapVector),
        .mepcOut    (mepcOut)
    );

    // both memories wrap at 64 words
    assign instruction = imem[pc[7:2]];
    assign memReadData = dmem[memAddr[7:2]];

    always @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < progWords; i++) begin
                dmem[i] <= {i[7:0], i[7:0] ^ 8'hA5, i[7:0] * 8'd3, ~i[7:0]};
            end
        end else if (memWr) begin
            for (int i = 0; i < 4; i++) begin
                if (wrMask[i]) begin
                    dmem[memAddr[7:2]][8*i +: 8] <= memWriteData[8*i +: 8];
                end
            end
        end
    end

    // galois lfsr, one step per bit
    function automatic logic [31:0] takeBits(input int n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            lfsrState = lfsrState[0] ? ((lfsrState >> 1) ^ lfsrPoly) : (lfsrState >> 1);
            value = {value[30:0], lfsrState[0]};
        end
        return value;
    endfunction

    function automatic logic [31:0] encAddi(input logic [4:0] rd, input logic [11:0] imm);
        return {imm, 5'd0, f3Add, rd, opOpImm};
    endfunction

    function automatic logic [31:0] encCsrrw(input logic [11:0] csr, input logic [4:0] rs1);
        return {csr, rs1, f3Csrrw, 5'd0, opSystem};
    endfunction

    function automatic int kindFor(input int test, input logic [2:0] cat);
        int mix [numTests][8];
        // 0 rtype 1 addi 2 lui 3 load 4 store 5 branch 6 jal 7 csrrw 8 ecall 9 mret
        mix = '{'{0, 0, 1, 1, 2, 4, 4, 0}, '{1, 3, 3, 4, 4, 3, 4, 1},
                '{0, 1, 5, 5, 6, 4, 4, 5}, '{7, 7, 8, 9, 1, 4, 0, 8},
                '{0, 1, 3, 4, 5, 6, 7, 8}};
        return mix[test][cat];
    endfunction

    function automatic logic [31:0] randomInstr(input int test);
        int          kind;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  sel;
        logic [7:0]  imm8;
        logic [11:0] imm12;
        logic [19:0] imm20;
        logic [31:0] off;
        logic [11:0] csrs [4];
        csrs = '{csrMstatus, csrMtvec, csrMepc, csrMcause};
        kind = kindFor(test, 3'(takeBits(3)));
        rd   = 5'(takeBits(3));
        rs1  = 5'(takeBits(3));
        rs2  = 5'(takeBits(3));
        sel  = 3'(takeBits(3));
        case (kind)
            0: begin
                case (sel)
                    1: return {7'h20, rs2, rs1, f3Add, rd, opOp};
                    2: return {7'h00, rs2, rs1, f3And, rd, opOp};
                    3: return {7'h00, rs2, rs1, f3Or, rd, opOp};
                    4: return {7'h00, rs2, rs1, f3Xor, rd, opOp};
                    5: return {7'h00, rs2, rs1, f3Slt, rd, opOp};
                    default: return {7'h00, rs2, rs1, f3Add, rd, opOp};
                endcase
            end
            1: begin
                imm12 = 12'(takeBits(12));
                return {imm12, rs1, f3Add, rd, opOpImm};
            end
            2: begin
                imm20 = 20'(takeBits(20));
                return {imm20, rd, opLui};
            end
            3: begin
                imm8 = 8'(takeBits(8));
                if (sel[1]) begin
                    imm8[1:0] = 2'b00;
                    return {4'd0, imm8, 5'd0, f3Lw, rd, opLoad};
                end
                return {4'd0, imm8, 5'd0, sel[0] ? f3Lbu : f3Lb, rd, opLoad};
            end
            4: begin
                imm8 = 8'(takeBits(8));
                if (sel[0]) begin
                    imm8[1:0] = 2'b00;
                end
                return {4'd0, imm8[7:5], rs2, 5'd0, sel[0] ? f3Sw : f3Sb, imm8[4:0], opStore};
            end
            5: begin
                // -8 to +7 words
                off = {{26{sel[2]}}, sel, 1'(takeBits(1)), 2'b00};
                return {off[12], off[10:5], rs2, rs1, sel[0] ? f3Bne : f3Beq,
                        off[4:1], off[11], opBranch};
            end
            6: begin
                off = {{26{sel[2]}}, sel, 1'(takeBits(1)), 2'b00};
                return {off[20], off[10:1], off[11], off[19:12], rd, opJal};
            end
            7: return {csrs[sel[1:0]], rs1, f3Csrrw, rd, opSystem};
            8: return 32'h00000073;
            default: return 32'h30200073;
        endcase
    endfunction

    task automatic loadProgram(input int test, input logic [11:0] mtvecValue);
        for (int i = 1; i < 8; i++) begin
            imem[i-1] = encAddi(i[4:0], 12'(takeBits(12)));
        end
        imem[7]  = encAddi(5'd1, mtvecValue);
        imem[8]  = encCsrrw(csrMtvec, 5'd1);
        imem[9]  = encAddi(5'd1, 12'd8);
        imem[10] = encCsrrw(csrMstatus, 5'd1);
        for (int i = 11; i < progWords; i++) begin
            imem[i] = randomInstr(test);
        end
        // mret handlers at the base and the vectored irq entry
        imem[49] = 32'h30200073;
        imem[60] = 32'h30200073;
    endtask

    task automatic runTest(input int test);
        int startErrors;
        int waitCount;
        startErrors = errors;
        reset = 1'b1;
        irq = 1'b0;
        irqEnable = (test >= 3);
        loadProgram(test, (test == 4) ? 12'h0C5 : 12'h0F0);
        for (int i = 0; i < resetCycles; i++) begin
            @(negedge clk);
        end
        reset = 1'b0;
        waitCount = 0;
        while (!ready && waitCount < readyTimeout) begin
            @(negedge clk);
            waitCount++;
        end
        if (!ready) begin
            $display("test %0d: timeout, the checker never became ready after reset", test);
            timedOut = 1'b1;
            failedTests++;
            return;
        end
        for (int i = 0; i < runCycles; i++) begin
            @(negedge clk);
            irq = irqEnable && (takeBits(4) == 32'd0);
        end
        irq = 1'b0;
        if (errors == startErrors) begin
            $display("test %0d %s: pass", test, testNames[test]);
        end else begin
            $display("test %0d %s: FAIL with %0d errors", test, testNames[test],
                     errors - startErrors);
            failedTests++;
        end
    endtask

    initial begin
        @(negedge clk);
        for (int t = 0; t < numTests; t++) begin
            runTest(t);
            if (timedOut) begin
                break;
            end
        end
        $display("tests %0d, failed %0d, checker errors %0d", numTests, failedTests, errors);
        if (failedTests == 0 && !timedOut) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

/* verification/cpu_props.sv */
`timescale 1ns/1ps

module cpu_props (
    input logic        clk,
    input logic        reset,
    input logic        memWr,
    input logic        ecall,
    input logic [4:0]  rs1Addr,
    input logic [31:0] imm,
    input logic [31:0] memAddr,
    input logic [31:0] pc,
    input logic [31:0] trapVector,
    input logic [31:0] mepcOut
);

    // a store based on x0 addresses its bare offset
    x0ReadsZero: assert property (@(posedge clk) disable iff (reset)
        memWr && rs1Addr == 5'd0 |-> memAddr == imm)
        else $error("store based on x0 did not address its bare offset");

    noStoreInReset: assert property (@(posedge clk) reset |-> !memWr)
        else $error("memWr high during reset");

    ecallEntry: assert property (@(posedge clk) disable iff (reset)
        ecall |=> pc == $past(trapVector) && mepcOut == $past(pc))
        else $error("pc or mepc after ecall is wrong");

endmodule
